/* Makefile */
TOOL       := verilator
TOP        := tb_data_path
FILELIST   := verilog.f
FLAGS      := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/data_path_top.sv */
module data_path_top
    import dp_pkg::*;
#(
    parameter int N_LANES = LANES,
    parameter int DATA_W  = LANE_W,
    parameter int DEPTH   = FIFO_DEPTH
) (
    input  logic                             clk,
    input  logic                             rst,
    // input stream
    input  logic [N_LANES*DATA_W-1:0]        i_tdata,
    input  logic                             i_tvalid,
    output logic                             o_tready,
    input  logic                             i_tlast,
    input  logic [N_LANES*KEEP_PER_LANE-1:0] i_tkeep,
    // output stream
    output logic [N_LANES*DATA_W-1:0]        o_tdata,
    output logic                             o_tvalid,
    input  logic                             i_tready,
    output logic                             o_tlast,
    output logic [N_LANES*KEEP_PER_LANE-1:0] o_tkeep,
    // control
    input  logic                             i_done_loader,
    input  logic                             i_ap_done,
    input  lane_op_t                         i_op,
    input  logic [DATA_W-1:0]                i_coef,
    output logic                             o_done_steady
);

    localparam int EW = DATA_W + 2; // {last, valid, data}

    logic                      done_steady;
    logic                      tready_steady;
    logic                      tready_bypass;
    logic                      in_push;
    logic                      in_last;
    logic [N_LANES-1:0]        in_lane_valid;
    logic [N_LANES-1:0]        in_full;
    logic [N_LANES-1:0]        in_empty;
    logic [N_LANES-1:0]        fifo_valid;
    logic [N_LANES-1:0]        fifo_last;
    logic [N_LANES*DATA_W-1:0] fifo_data;
    logic                      pe_en;
    logic [N_LANES-1:0]        pe_valid;
    logic [N_LANES-1:0]        pe_last;
    logic [N_LANES*DATA_W-1:0] pe_data;
    logic                      out_almost_full;

    stream_ingress #(
        .N_LANES (N_LANES)
    ) u_ingress (
        .clk             (clk),
        .rst             (rst),
        .i_done_loader   (i_done_loader),
        .i_ap_done       (i_ap_done),
        .i_tvalid        (i_tvalid),
        .i_tkeep         (i_tkeep),
        .i_tlast         (i_tlast),
        .i_fifo_full     (in_full),
        .o_done_steady   (done_steady),
        .o_tready_steady (tready_steady),
        .o_push          (in_push),
        .o_lane_valid    (in_lane_valid),
        .o_last          (in_last)
    );

    // whole beat moves into the pes together
    assign pe_en = ~|in_empty && !out_almost_full;

    for (genvar l = 0; l < N_LANES; l++) begin : g_lane
        sync_fifo #(
            .W     (EW),
            .DEPTH (DEPTH)
        ) u_in_fifo (
            .clk           (clk),
            .rst           (rst),
            .i_push        (in_push),
            .i_pop         (pe_en),
            .i_din         ({in_last, in_lane_valid[l], i_tdata[l*DATA_W +: DATA_W]}),
            .o_dout        ({fifo_last[l], fifo_valid[l], fifo_data[l*DATA_W +: DATA_W]}),
            .o_empty       (in_empty[l]),
            .o_full        (in_full[l]),
            .o_almost_full ()
        );

        lane_pe #(
            .DATA_W (DATA_W)
        ) u_pe (
            .clk     (clk),
            .rst     (rst),
            .i_en    (pe_en),
            .i_valid (fifo_valid[l]),
            .i_last  (fifo_last[l]),
            .i_data  (fifo_data[l*DATA_W +: DATA_W]),
            .i_op    (i_op),
            .i_coef  (i_coef),
            .o_valid (pe_valid[l]),
            .o_last  (pe_last[l]),
            .o_data  (pe_data[l*DATA_W +: DATA_W])
        );
    end

    stream_egress #(
        .N_LANES (N_LANES),
        .DATA_W  (DATA_W),
        .DEPTH   (DEPTH)
    ) u_egress (
        .clk             (clk),
        .rst             (rst),
        .i_done_steady   (done_steady),
        .i_push          (|pe_valid),      // all-invalid beats dropped here
        .i_lane_valid    (pe_valid),
        .i_lane_last     (pe_last),
        .i_lane_data     (pe_data),
        .i_tready        (i_tready),
        .i_in_tdata      (i_tdata),
        .i_in_tvalid     (i_tvalid),
        .i_in_tlast      (i_tlast),
        .i_in_tkeep      (i_tkeep),
        .o_almost_full   (out_almost_full),
        .o_tdata         (o_tdata),
        .o_tvalid        (o_tvalid),
        .o_tlast         (o_tlast),
        .o_tkeep         (o_tkeep),
        .o_tready_bypass (tready_bypass)
    );

    assign o_tready      = done_steady ? tready_steady : tready_bypass;
    assign o_done_steady = done_steady;

endmodule

/* design/dp_pkg.sv */
package dp_pkg;

    // beat geometry
    localparam int LANES         = 4;
    localparam int LANE_W        = 32;
    localparam int KEEP_PER_LANE = LANE_W / 8; // byte enables per lane

    // lane fifo depth, power of two
    localparam int FIFO_DEPTH = 16;

    // per-lane operation
    typedef enum logic [1:0] {
        OP_PASS  = 2'd0, // copy word
        OP_SCALE = 2'd1, // word * coef, low bits
        OP_MACC  = 2'd2  // running sum of word * coef
    } lane_op_t;

endpackage

/* design/lane_pe.sv */
module lane_pe
    import dp_pkg::*;
#(
    parameter int DATA_W = LANE_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_en,
    input  logic              i_valid,
    input  logic              i_last,
    input  logic [DATA_W-1:0] i_data,
    input  lane_op_t          i_op,
    input  logic [DATA_W-1:0] i_coef,
    output logic              o_valid,
    output logic              o_last,
    output logic [DATA_W-1:0] o_data
);

    logic [2*DATA_W-1:0] prod;
    logic [DATA_W-1:0]   acc;
    logic [DATA_W-1:0]   acc_sum;
    logic [DATA_W-1:0]   result;

    assign prod    = i_data * i_coef;
    assign acc_sum = acc + prod[DATA_W-1:0];  // wraps at lane width

    always_comb begin
        case (i_op)
            OP_PASS:  result = i_data;
            OP_SCALE: result = prod[DATA_W-1:0];
            OP_MACC:  result = acc_sum;
            default:  result = i_data;
        endcase
        if (!i_valid) begin
            result = '0; // masked lane
        end
    end

    // accumulator, restarts after a packet end
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (i_en) begin
            if (i_last) begin
                acc <= '0;
            end else if (i_valid && i_op == OP_MACC) begin
                acc <= acc_sum;
            end
        end
    end

    // strobes last one cycle per taken entry
    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            o_valid <= i_en && i_valid;
            o_last  <= i_en && i_last;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_data <= result;
        end
    end

endmodule

/* design/stream_egress.sv */
module stream_egress
    import dp_pkg::*;
#(
    parameter int N_LANES = LANES,
    parameter int DATA_W  = LANE_W,
    parameter int DEPTH   = FIFO_DEPTH
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_done_steady,
    input  logic                             i_push,
    input  logic [N_LANES-1:0]               i_lane_valid,
    input  logic [N_LANES-1:0]               i_lane_last,
    input  logic [N_LANES*DATA_W-1:0]        i_lane_data,
    input  logic                             i_tready,
    input  logic [N_LANES*DATA_W-1:0]        i_in_tdata,
    input  logic                             i_in_tvalid,
    input  logic                             i_in_tlast,
    input  logic [N_LANES*KEEP_PER_LANE-1:0] i_in_tkeep,
    output logic                             o_almost_full,
    output logic [N_LANES*DATA_W-1:0]        o_tdata,
    output logic                             o_tvalid,
    output logic                             o_tlast,
    output logic [N_LANES*KEEP_PER_LANE-1:0] o_tkeep,
    output logic                             o_tready_bypass
);

    localparam int EW = DATA_W + 2; // {last, valid, data}

    logic [N_LANES-1:0]               out_empty;
    logic [N_LANES-1:0]               out_af;
    logic [N_LANES-1:0]               head_valid;
    logic [N_LANES-1:0]               head_last;
    logic [N_LANES*DATA_W-1:0]        steady_tdata;
    logic [N_LANES*KEEP_PER_LANE-1:0] steady_tkeep;
    logic                             steady_tvalid;
    logic                             steady_tlast;
    logic                             pop;

    // beat leaves only when every lane has its entry
    assign steady_tvalid = ~|out_empty;
    assign steady_tlast  = &head_last;
    assign pop           = i_done_steady && steady_tvalid && i_tready;

    for (genvar l = 0; l < N_LANES; l++) begin : g_out_lane
        sync_fifo #(
            .W     (EW),
            .DEPTH (DEPTH)
        ) u_out_fifo (
            .clk           (clk),
            .rst           (rst),
            .i_push        (i_push),
            .i_pop         (pop),
            .i_din         ({i_lane_last[l], i_lane_valid[l], i_lane_data[l*DATA_W +: DATA_W]}),
            .o_dout        ({head_last[l], head_valid[l], steady_tdata[l*DATA_W +: DATA_W]}),
            .o_empty       (out_empty[l]),
            .o_full        (),
            .o_almost_full (out_af[l])
        );

        assign steady_tkeep[l*KEEP_PER_LANE +: KEEP_PER_LANE] = {KEEP_PER_LANE{head_valid[l]}};
    end

    // any lane near full stalls the pes
    assign o_almost_full = |out_af;

    // load phase bypass
    assign o_tready_bypass = i_tready;

    always_comb begin
        if (i_done_steady) begin
            o_tdata  = steady_tdata;
            o_tvalid = steady_tvalid;
            o_tlast  = steady_tlast;
            o_tkeep  = steady_tkeep;
        end else begin
            o_tdata  = i_in_tdata;
            o_tvalid = i_in_tvalid;
            o_tlast  = i_in_tlast;
            o_tkeep  = i_in_tkeep;
        end
    end

endmodule

/* design/stream_ingress.sv */
module stream_ingress
    import dp_pkg::*;
#(
    parameter int N_LANES = LANES
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_done_loader,
    input  logic                               i_ap_done,
    input  logic                               i_tvalid,
    input  logic [N_LANES*KEEP_PER_LANE-1:0]   i_tkeep,
    input  logic                               i_tlast,
    input  logic [N_LANES-1:0]                 i_fifo_full,
    output logic                               o_done_steady,
    output logic                               o_tready_steady,
    output logic                               o_push,
    output logic [N_LANES-1:0]                 o_lane_valid,
    output logic                               o_last
);

    typedef enum logic {
        ST_LOAD   = 1'b0,
        ST_STEADY = 1'b1
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_LOAD;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_LOAD: begin
                if (i_done_loader) begin
                    state_nxt = ST_STEADY;
                end
            end
            ST_STEADY: begin
                if (i_ap_done) begin
                    state_nxt = ST_LOAD;
                end
            end
            default: state_nxt = ST_LOAD;
        endcase
    end

    assign o_done_steady = (state == ST_STEADY);

    // room in every lane fifo
    assign o_tready_steady = ~|i_fifo_full;

    // one entry per lane for each accepted beat
    assign o_push = o_done_steady && i_tvalid && o_tready_steady;
    assign o_last = i_tlast;

    // a lane counts only when all its byte enables are set
    for (genvar l = 0; l < N_LANES; l++) begin : g_lane_valid
        assign o_lane_valid[l] = &i_tkeep[l*KEEP_PER_LANE +: KEEP_PER_LANE];
    end

endmodule

/* design/sync_fifo.sv */
module sync_fifo
    import dp_pkg::*;
#(
    parameter int W     = LANE_W + 2,
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         i_push,
    input  logic         i_pop,
    input  logic [W-1:0] i_din,
    output logic [W-1:0] o_dout,
    output logic         o_empty,
    output logic         o_full,
    output logic         o_almost_full
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] CNT_FULL = (AW + 1)'(DEPTH);
    localparam logic [AW:0] CNT_AF   = (AW + 1)'(DEPTH - 1); // one free slot left

    logic [W-1:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = i_push && !o_full;  // push on full is dropped
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry visible without a pop
    assign o_dout        = mem[rd_ptr];
    assign o_empty       = (count == '0);
    assign o_full        = (count == CNT_FULL);
    assign o_almost_full = (count >= CNT_AF);

endmodule

/* tests/tb_data_path.sv */
module tb_data_path
    import dp_pkg::*;
();

    localparam int DW        = LANES * LANE_W;
    localparam int KW        = LANES * KEEP_PER_LANE;
    localparam int BW        = DW + KW + 1;  // {last, keep, data}
    localparam int CLK_P     = 20;
    localparam int MAX_BEATS = 332;          // 40 + 62 + 60 + up to 160 + 10
    localparam int TIMEOUT   = (MAX_BEATS * 40 + 2000) * CLK_P;

    logic              clk;
    logic              rst;
    logic [DW-1:0]     i_tdata;
    logic              i_tvalid;
    logic              o_tready;
    logic              i_tlast;
    logic [KW-1:0]     i_tkeep;
    logic [DW-1:0]     o_tdata;
    logic              o_tvalid;
    logic              i_tready;
    logic              o_tlast;
    logic [KW-1:0]     o_tkeep;
    logic              i_done_loader;
    logic              i_ap_done;
    lane_op_t          i_op;
    logic [LANE_W-1:0] i_coef;
    logic              o_done_steady;

    logic [31:0]       seed;
    logic [BW-1:0]     exp_q[$];
    logic [BW-1:0]     exp_beat;
    logic [LANE_W-1:0] model_acc[LANES];
    logic              in_steady;
    logic              saw_stall;
    int                ready_mode;  // 1 random, 2 long stretches
    int                ready_run;
    int                checks;
    int                errors;

    data_path_top u_dut (.*);

    always #(CLK_P / 2) clk = ~clk;

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [DW-1:0] rand_data();
        logic [DW-1:0] d;
        d = '0;
        for (int l = 0; l < LANES; l++) begin
            d[l*LANE_W +: LANE_W] = rand32();
        end
        return d;
    endfunction

    // mostly full lanes, some random partial nibbles
    function automatic logic [KW-1:0] rand_keep();
        logic [31:0]   r;
        logic [KW-1:0] k;
        k = '0;
        for (int l = 0; l < LANES; l++) begin
            r = rand32();
            if (r[31:30] != 2'b00) begin
                k[l*KEEP_PER_LANE +: KEEP_PER_LANE] = '1;
            end else begin
                k[l*KEEP_PER_LANE +: KEEP_PER_LANE] = r[16 +: KEEP_PER_LANE];
            end
        end
        return k;
    endfunction

    // expected lane result
    function automatic logic [LANE_W-1:0] ref_lane(input logic [LANE_W-1:0] word,
                                                   input logic valid, input lane_op_t op,
                                                   input logic [LANE_W-1:0] coef,
                                                   input logic [LANE_W-1:0] acc);
        logic [LANE_W-1:0] prod;
        prod = word * coef;  // low bits only
        if (!valid) begin
            return '0;
        end
        case (op)
            OP_SCALE: return prod;
            OP_MACC:  return acc + prod;
            default:  return word;
        endcase
    endfunction

    task automatic check_val(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                             input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drive_ready();
        logic [31:0] r;
        r = rand32();
        if (ready_mode == 1) begin
            i_tready = r[31] | r[30];
        end else if (ready_run > 0) begin
            ready_run = ready_run - 1;
        end else begin
            i_tready  = !i_tready;
            ready_run = i_tready ? int'(r[31:29]) + 2 : int'(r[31:27]) + 32;
        end
    endtask

    // model side of an accepted beat
    task automatic record_beat(input logic [DW-1:0] data, input logic [KW-1:0] keep,
                               input logic last);
        logic [DW-1:0]     e_data;
        logic [KW-1:0]     e_keep;
        logic              valid;
        logic              any_valid;
        logic [LANE_W-1:0] res;
        e_data    = '0;
        e_keep    = '0;
        any_valid = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            valid = &keep[l*KEEP_PER_LANE +: KEEP_PER_LANE];
            res   = ref_lane(data[l*LANE_W +: LANE_W], valid, i_op, i_coef, model_acc[l]);
            e_data[l*LANE_W +: LANE_W]               = res;
            e_keep[l*KEEP_PER_LANE +: KEEP_PER_LANE] = {KEEP_PER_LANE{valid}};
            any_valid = any_valid | valid;
            if (last) begin
                model_acc[l] = '0;
            end else if (valid && i_op == OP_MACC) begin
                model_acc[l] = res;
            end
        end
        if (!in_steady) begin
            exp_q.push_back({last, keep, data});  // bypass is transparent
        end else if (any_valid) begin
            exp_q.push_back({last, e_keep, e_data});
        end
    endtask

    // starts and ends just after a falling edge
    task automatic send_beat(input logic [DW-1:0] data, input logic [KW-1:0] keep,
                             input logic last);
        logic taken;
        taken    = 1'b0;
        i_tdata  = data;
        i_tkeep  = keep;
        i_tlast  = last;
        i_tvalid = 1'b1;
        while (!taken) begin
            drive_ready();
            #1;
            if (in_steady && !o_tready) begin
                saw_stall = 1'b1;
            end
            taken = o_tready;
            if (taken) begin
                record_beat(data, keep, last);  // handshake at the next rising edge
            end
            @(negedge clk);
        end
        i_tvalid = 1'b0;
    endtask

    task automatic send_random(input int n);
        logic [31:0] r;
        for (int b = 0; b < n; b++) begin
            r = rand32();
            if (r[31:30] == 2'b00) begin
                drive_ready();
                @(negedge clk);
            end
            send_beat(rand_data(), rand_keep(), r[29:27] == 3'b000);
        end
    endtask

    // packets close with a full-keep last beat
    task automatic send_packets(input int n);
        logic [31:0] r;
        for (int p = 0; p < n; p++) begin
            r = rand32();
            for (int b = 0; b < int'(r[31:29]); b++) begin
                send_beat(rand_data(), rand_keep(), 1'b0);
            end
            send_beat(rand_data(), '1, 1'b1);
        end
    endtask

    task automatic drain();
        i_tvalid = 1'b0;
        while (exp_q.size() != 0) begin
            drive_ready();
            @(negedge clk);
        end
        for (int c = 0; c < 10; c++) begin  // dropped beats still leave the pes
            drive_ready();
            @(negedge clk);
        end
    endtask

    task automatic start_steady(input lane_op_t op, input logic [LANE_W-1:0] coef);
        i_op          = op;
        i_coef        = coef;
        i_done_loader = 1'b1;
        drive_ready();
        check_val(o_done_steady, 1'b0, "done_steady in the loader pulse cycle");
        @(negedge clk);
        i_done_loader = 1'b0;
        check_val(o_done_steady, 1'b1, "done_steady one cycle after the loader pulse");
        in_steady = 1'b1;
    endtask

    task automatic stop_steady();
        drain();
        i_ap_done = 1'b1;
        drive_ready();
        check_val(o_done_steady, 1'b1, "done_steady in the ap_done cycle");
        @(negedge clk);
        i_ap_done = 1'b0;
        check_val(o_done_steady, 1'b0, "done_steady one cycle after ap_done");
        in_steady = 1'b0;
    endtask

    // scoreboard, pops one expected beat per output handshake
    always @(posedge clk) begin
        if (!rst) begin
            if (!o_done_steady) begin
                check_val(o_tready, i_tready, "bypass tready");
            end
            if (o_tvalid && i_tready) begin
                if (exp_q.size() == 0) begin
                    errors = errors + 1;
                    $display("Error at %0t: an output beat came with none expected", $time);
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_val(o_tdata, exp_beat[DW-1:0], "tdata");
                    check_val(o_tkeep, exp_beat[DW +: KW], "tkeep");
                    check_val(o_tlast, exp_beat[BW-1], "tlast");
                end
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Error: watchdog stopped the run at %0t with %0d beats still expected",
                 $time, exp_q.size());
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        seed          = 32'd92;
        clk           = 1'b0;
        rst           = 1'b1;
        i_tdata       = '0;
        i_tvalid      = 1'b0;
        i_tlast       = 1'b0;
        i_tkeep       = '0;
        i_tready      = 1'b0;
        i_done_loader = 1'b0;
        i_ap_done     = 1'b0;
        i_op          = OP_PASS;
        i_coef        = '0;
        in_steady     = 1'b0;
        saw_stall     = 1'b0;
        ready_mode    = 1;
        ready_run     = 0;
        checks        = 0;
        errors        = 0;
        for (int l = 0; l < LANES; l++) begin
            model_acc[l] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_val(o_done_steady, 1'b0, "done_steady after reset");

        send_random(40);  // load phase bypass
        drain();
        start_steady(OP_PASS, '0);
        send_random(60);
        send_beat(rand_data(), '0, 1'b0);  // all lanes masked, beat dropped
        send_beat(rand_data(), '0, 1'b1);
        stop_steady();
        start_steady(OP_SCALE, rand32());
        send_random(60);
        stop_steady();

        // macc packets under heavy output back-pressure
        ready_mode = 2;
        saw_stall  = 1'b0;
        start_steady(OP_MACC, rand32());
        send_packets(20);
        check_val(saw_stall, 1'b1, "input ready dropped under back-pressure");
        stop_steady();

        ready_mode = 1;
        send_random(10);
        drain();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/dp_pkg.sv
design/sync_fifo.sv
design/stream_ingress.sv
design/lane_pe.sv
design/stream_egress.sv
design/data_path_top.sv
tests/tb_data_path.sv
